// ==== common/rv_core_consts.svh ====
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath width
`define RV_XLEN 32

// Register file address width
`define RV_REG_AW 5

// First fetch address after reset
`define RV_RESET_PC 32'h8000_0000

`endif

// ==== common/rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_consts.svh"

package rv_core_pkg;

    // RV32I major opcodes
    typedef enum logic [6:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        OP       = 7'b0110011,
        OP_IMM   = 7'b0010011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        JAL      = 7'b1101111,
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        SYSTEM   = 7'b1110011,
        MISC_MEM = 7'b0001111
    } opcode_t;

    typedef enum logic [1:0] {
        RS1,
        PC,
        CONST0
    } alu_a_t;

    typedef enum logic [1:0] {
        RS2,
        IMM,
        PC_INCR
    } alu_b_t;

    // Compare ops return 0 or 1
    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        LT,
        LTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        EQ,
        NE,
        GE,
        GEU
    } alu_op_t;

    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_AW-1:0] rs2;
        logic [`RV_REG_AW-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_AW-1:0] rd;
        opcode_t              opcode;
    } inst_ris_t;

    typedef struct packed {
        logic [19:0]          imm_hi;
        logic [`RV_REG_AW-1:0] rd;
        opcode_t              opcode;
    } inst_uj_t;

    // Same instruction word, two field layouts
    typedef union packed {
        inst_ris_t ris;
        inst_uj_t  uj;
    } inst_u;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   imm;
        alu_a_t                alu_a;
        alu_b_t                alu_b;
        alu_op_t               alu_op;
        logic [`RV_REG_AW-1:0] rs1_addr;
        logic [`RV_REG_AW-1:0] rs2_addr;
        logic [`RV_REG_AW-1:0] rd_addr;
        logic                  reg_we;
        logic                  jal;
        logic                  jalr;
        logic                  branch;
    } decoder_t;

endpackage

`default_nettype wire

// ==== common/dec_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

interface dec_if
    import rv_core_pkg::*;
();

    decoder_t            ctrl;
    logic                illegal;
    logic                fencei;
    // Register file read data for ctrl's source addresses
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;

    modport dec (
        output ctrl,
        output illegal,
        output fencei
    );

    modport rf (
        input  ctrl,
        output rs1_data,
        output rs2_data
    );

    modport exe (
        input ctrl,
        input illegal,
        input fencei,
        input rs1_data,
        input rs2_data
    );

endinterface

`default_nettype wire

// ==== common/wb_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

interface wb_if ();

    logic                  we;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   data;
    logic [`RV_XLEN-1:0]   next_pc;
    logic                  illegal;
    logic                  fencei;

    modport src (
        output we,
        output rd,
        output data,
        output next_pc,
        output illegal,
        output fencei
    );

    modport sink (
        input we,
        input rd,
        input data,
        input next_pc,
        input illegal,
        input fencei
    );

endinterface

`default_nettype wire

// ==== idu/idu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module idu
    import rv_core_pkg::*;
(
    input  inst_u inst,
    dec_if.dec    d
);

    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_b;
    logic [`RV_XLEN-1:0] imm_u;
    logic [`RV_XLEN-1:0] imm_j;
    decoder_t            ctrl;
    logic                illegal;
    logic                fencei;
    logic                use_rs1;
    logic                use_rs2;

    // Immediates rebuilt from the two layouts
    assign imm_i = {{20{inst.ris.funct7[6]}}, inst.ris.funct7, inst.ris.rs2};
    assign imm_b = {{20{inst.ris.funct7[6]}}, inst.ris.rd[0], inst.ris.funct7[5:0],
                    inst.ris.rd[4:1], 1'b0};
    assign imm_u = {inst.uj.imm_hi, 12'b0};
    assign imm_j = {{12{inst.uj.imm_hi[19]}}, inst.uj.imm_hi[7:0], inst.uj.imm_hi[8],
                    inst.uj.imm_hi[18:9], 1'b0};

    always_comb begin
        ctrl        = '0;
        ctrl.imm    = imm_i;
        ctrl.alu_a  = RS1;
        ctrl.alu_b  = RS2;
        ctrl.alu_op = ADD;
        illegal     = 1'b0;
        fencei      = 1'b0;
        use_rs1     = 1'b0;
        use_rs2     = 1'b0;
        case (inst.ris.opcode)
            LUI: begin
                ctrl.imm    = imm_u;
                ctrl.alu_a  = CONST0;
                ctrl.alu_b  = IMM;
                ctrl.reg_we = 1'b1;
            end
            AUIPC: begin
                ctrl.imm    = imm_u;
                ctrl.alu_a  = PC;
                ctrl.alu_b  = IMM;
                ctrl.reg_we = 1'b1;
            end
            OP: begin
                ctrl.reg_we = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                case ({inst.ris.funct7, inst.ris.funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = SUB;
                    {7'b0000000, 3'b001}: ctrl.alu_op = SLL;
                    {7'b0000000, 3'b010}: ctrl.alu_op = LT;
                    {7'b0000000, 3'b011}: ctrl.alu_op = LTU;
                    {7'b0000000, 3'b100}: ctrl.alu_op = XOR;
                    {7'b0000000, 3'b101}: ctrl.alu_op = SRL;
                    {7'b0100000, 3'b101}: ctrl.alu_op = SRA;
                    {7'b0000000, 3'b110}: ctrl.alu_op = OR;
                    {7'b0000000, 3'b111}: ctrl.alu_op = AND;
                    // M extension ends up here too
                    default: illegal = 1'b1;
                endcase
            end
            OP_IMM: begin
                ctrl.alu_b  = IMM;
                ctrl.reg_we = 1'b1;
                use_rs1     = 1'b1;
                case (inst.ris.funct3)
                    3'b000: ctrl.alu_op = ADD;
                    3'b010: ctrl.alu_op = LT;
                    3'b011: ctrl.alu_op = LTU;
                    3'b100: ctrl.alu_op = XOR;
                    3'b110: ctrl.alu_op = OR;
                    3'b111: ctrl.alu_op = AND;
                    3'b001: begin
                        ctrl.alu_op = SLL;
                        illegal     = inst.ris.funct7 != 7'b0000000;
                    end
                    default: begin
                        if (inst.ris.funct7 == 7'b0000000) begin
                            ctrl.alu_op = SRL;
                        end else if (inst.ris.funct7 == 7'b0100000) begin
                            ctrl.alu_op = SRA;
                        end else begin
                            illegal = 1'b1;
                        end
                    end
                endcase
            end
            JAL: begin
                ctrl.imm    = imm_j;
                ctrl.alu_a  = PC;
                ctrl.alu_b  = PC_INCR;
                ctrl.reg_we = 1'b1;
                ctrl.jal    = 1'b1;
            end
            JALR: begin
                // ALU computes the link, exu forms the target
                ctrl.alu_a  = PC;
                ctrl.alu_b  = PC_INCR;
                ctrl.reg_we = 1'b1;
                ctrl.jalr   = 1'b1;
                use_rs1     = 1'b1;
                illegal     = inst.ris.funct3 != 3'b000;
            end
            BRANCH: begin
                ctrl.imm    = imm_b;
                ctrl.branch = 1'b1;
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
                case (inst.ris.funct3)
                    3'b000:  ctrl.alu_op = EQ;
                    3'b001:  ctrl.alu_op = NE;
                    3'b100:  ctrl.alu_op = LT;
                    3'b101:  ctrl.alu_op = GE;
                    3'b110:  ctrl.alu_op = LTU;
                    3'b111:  ctrl.alu_op = GEU;
                    default: illegal = 1'b1;
                endcase
            end
            MISC_MEM: begin
                // fence is a no-op
                case (inst.ris.funct3)
                    3'b000:  fencei = 1'b0;
                    3'b001:  fencei = 1'b1;
                    default: illegal = 1'b1;
                endcase
            end
            // No memory port or CSR file
            LOAD, STORE, SYSTEM: illegal = 1'b1;
            default: illegal = 1'b1;
        endcase
        ctrl.rs1_addr = inst.ris.rs1 & {`RV_REG_AW{use_rs1}};
        ctrl.rs2_addr = inst.ris.rs2 & {`RV_REG_AW{use_rs2}};
        ctrl.rd_addr  = inst.uj.rd & {`RV_REG_AW{ctrl.reg_we}};
        if (ctrl.rd_addr == '0) begin
            ctrl.reg_we = 1'b0;
        end
    end

    assign d.ctrl    = ctrl;
    assign d.illegal = illegal;
    assign d.fencei  = fencei;

endmodule

`default_nettype wire

// ==== exu/exu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module exu
    import rv_core_pkg::*;
(
    input  logic [`RV_XLEN-1:0] pc,
    dec_if.exe                  d,
    wb_if.src                   w
);

    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] pc_seq;
    logic [`RV_XLEN-1:0] pc_rel;
    logic [`RV_XLEN-1:0] jalr_sum;

    always_comb begin
        case (d.ctrl.alu_a)
            RS1:     op_a = d.rs1_data;
            PC:      op_a = pc;
            default: op_a = '0;
        endcase
        case (d.ctrl.alu_b)
            RS2:     op_b = d.rs2_data;
            IMM:     op_b = d.ctrl.imm;
            default: op_b = `RV_XLEN'(4);
        endcase
    end

    always_comb begin
        alu_res = '0;
        case (d.ctrl.alu_op)
            ADD:     alu_res = op_a + op_b;
            SUB:     alu_res = op_a - op_b;
            SLL:     alu_res = op_a << op_b[4:0];
            SRL:     alu_res = op_a >> op_b[4:0];
            SRA:     alu_res = $signed(op_a) >>> op_b[4:0];
            XOR:     alu_res = op_a ^ op_b;
            OR:      alu_res = op_a | op_b;
            AND:     alu_res = op_a & op_b;
            LT:      alu_res[0] = $signed(op_a) < $signed(op_b);
            LTU:     alu_res[0] = op_a < op_b;
            EQ:      alu_res[0] = op_a == op_b;
            NE:      alu_res[0] = op_a != op_b;
            GE:      alu_res[0] = $signed(op_a) >= $signed(op_b);
            GEU:     alu_res[0] = op_a >= op_b;
            default: alu_res = '0;
        endcase
    end

    assign pc_seq   = pc + `RV_XLEN'(4);
    assign pc_rel   = pc + d.ctrl.imm;
    assign jalr_sum = d.rs1_data + d.ctrl.imm;

    // Bit 0 of alu_res is the branch outcome
    always_comb begin
        if (d.illegal) begin
            w.next_pc = pc_seq;
        end else if (d.ctrl.jal || (d.ctrl.branch && alu_res[0])) begin
            w.next_pc = pc_rel;
        end else if (d.ctrl.jalr) begin
            w.next_pc = {jalr_sum[`RV_XLEN-1:1], 1'b0};
        end else begin
            w.next_pc = pc_seq;
        end
    end

    assign w.we      = d.ctrl.reg_we & ~d.illegal;
    assign w.rd      = d.ctrl.rd_addr;
    assign w.data    = alu_res;
    assign w.illegal = d.illegal;
    assign w.fencei  = d.fencei;

endmodule

`default_nettype wire

// ==== hw/wbu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module wbu (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    dec_if.rf                     d,
    wb_if.sink                    w,
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  retire,
    output logic                  retire_we,
    output logic                  retire_illegal,
    output logic                  retire_fencei,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data
);

    logic [`RV_XLEN-1:0] regs [(1 << `RV_REG_AW)];

    // x0 is never written, so it reads zero
    assign d.rs1_data = regs[d.ctrl.rs1_addr];
    assign d.rs2_data = regs[d.ctrl.rs2_addr];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < (1 << `RV_REG_AW); i++) begin
                regs[i] <= '0;
            end
            pc             <= `RV_RESET_PC;
            retire         <= 1'b0;
            retire_we      <= 1'b0;
            retire_illegal <= 1'b0;
            retire_fencei  <= 1'b0;
        end else begin
            retire         <= inst_valid;
            retire_we      <= inst_valid & w.we;
            retire_illegal <= inst_valid & w.illegal;
            retire_fencei  <= inst_valid & w.fencei;
            if (inst_valid) begin
                pc <= w.next_pc;
                if (w.we) begin
                    regs[w.rd] <= w.data;
                end
            end
        end
    end

    // Retire payload
    always_ff @(posedge clock) begin
        if (inst_valid) begin
            retire_rd   <= w.rd;
            retire_data <= w.data;
        end
    end

endmodule

`default_nettype wire

// ==== hw/core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module core_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  inst_valid,
    input  logic [`RV_XLEN-1:0]   inst,
    output logic [`RV_XLEN-1:0]   pc,
    output logic                  retire,
    output logic                  retire_we,
    output logic [`RV_REG_AW-1:0] retire_rd,
    output logic [`RV_XLEN-1:0]   retire_data,
    output logic                  retire_illegal,
    output logic                  retire_fencei
);

    dec_if i_dec ();
    wb_if  i_wb ();

    idu i_idu (
        .inst (inst),
        .d    (i_dec.dec)
    );

    exu i_exu (
        .pc (pc),
        .d  (i_dec.exe),
        .w  (i_wb.src)
    );

    wbu i_wbu (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .d              (i_dec.rf),
        .w              (i_wb.sink),
        .pc             (pc),
        .retire         (retire),
        .retire_we      (retire_we),
        .retire_illegal (retire_illegal),
        .retire_fencei  (retire_fencei),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data)
    );

endmodule

`default_nettype wire

// ==== testbench/core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module core_chk (
    input logic                  clock,
    input logic                  reset,
    input logic                  inst_valid,
    input logic                  retire,
    input logic                  retire_we,
    input logic                  retire_illegal,
    input logic [`RV_REG_AW-1:0] retire_rd
);

    // One retire per strobe, one cycle later
    a_retire_after_strobe: assert property (
        @(posedge clock) disable iff (reset) inst_valid |=> retire
    ) else $error("retire missing after strobe");

    a_no_stray_retire: assert property (
        @(posedge clock) disable iff (reset) !inst_valid |=> !retire
    ) else $error("retire without strobe");

    a_we_not_illegal: assert property (
        @(posedge clock) disable iff (reset) !(retire_we && retire_illegal)
    ) else $error("write on illegal instruction");

    a_rd_nonzero: assert property (
        @(posedge clock) disable iff (reset) retire_we |-> retire_rd != '0
    ) else $error("write to x0");

endmodule

bind core_top core_chk i_chk (
    .clock          (clock),
    .reset          (reset),
    .inst_valid     (inst_valid),
    .retire         (retire),
    .retire_we      (retire_we),
    .retire_illegal (retire_illegal),
    .retire_rd      (retire_rd)
);

`default_nettype wire

// ==== testbench/tb_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_core_consts.svh"

module tb_core
    import rv_core_pkg::*;
();

    localparam int NUM_INSTS      = 400;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 3 + 50;

    typedef struct packed {
        logic [`RV_XLEN-1:0]   next_pc;
        logic                  we;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_XLEN-1:0]   data;
        logic                  illegal;
        logic                  fencei;
    } expect_t;

    logic                  clock;
    logic                  reset;
    logic                  inst_valid;
    logic [`RV_XLEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   pc;
    logic                  retire;
    logic                  retire_we;
    logic [`RV_REG_AW-1:0] retire_rd;
    logic [`RV_XLEN-1:0]   retire_data;
    logic                  retire_illegal;
    logic                  retire_fencei;

    logic [15:0]           lfsr;
    logic [`RV_XLEN-1:0]   model_rf [32];
    logic [`RV_XLEN-1:0]   model_pc;
    logic                  sent_valid;
    logic [`RV_XLEN-1:0]   sent_inst;
    expect_t               exp_rec;
    int                    errors;
    int                    cycle_count;

    core_top i_dut (
        .clock          (clock),
        .reset          (reset),
        .inst_valid     (inst_valid),
        .inst           (inst),
        .pc             (pc),
        .retire         (retire),
        .retire_we      (retire_we),
        .retire_rd      (retire_rd),
        .retire_data    (retire_data),
        .retire_illegal (retire_illegal),
        .retire_fencei  (retire_fencei)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[0] ^ s[2] ^ s[3] ^ s[5], s[15:1]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    function automatic logic [`RV_XLEN-1:0] alu_ref(input logic [2:0] f3, input logic alt,
                                                    input logic [`RV_XLEN-1:0] a,
                                                    input logic [`RV_XLEN-1:0] b);
        logic [`RV_XLEN-1:0] r;
        case (f3)
            3'b000: r = alt ? a - b : a + b;
            3'b001: r = a << b[4:0];
            3'b010: r = {31'b0, $signed(a) < $signed(b)};
            3'b011: r = {31'b0, a < b};
            3'b100: r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110: r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    function automatic expect_t predict(input logic [`RV_XLEN-1:0] rf [32],
                                        input logic [`RV_XLEN-1:0] cur_pc,
                                        input logic [`RV_XLEN-1:0] word);
        expect_t             e;
        logic [2:0]          f3;
        logic [6:0]          f7;
        logic [`RV_XLEN-1:0] a;
        logic [`RV_XLEN-1:0] b;
        logic [`RV_XLEN-1:0] imm_i;
        logic [`RV_XLEN-1:0] imm_b;
        logic [`RV_XLEN-1:0] imm_u;
        logic [`RV_XLEN-1:0] imm_j;
        logic                taken;
        f3    = word[14:12];
        f7    = word[31:25];
        a     = rf[word[19:15]];
        b     = rf[word[24:20]];
        imm_i = {{20{word[31]}}, word[31:20]};
        imm_b = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
        imm_u = {word[31:12], 12'b0};
        imm_j = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
        e         = '0;
        e.next_pc = cur_pc + 4;
        e.rd      = word[11:7];
        taken     = 1'b0;
        case (word[6:0])
            LUI: begin
                e.we   = 1'b1;
                e.data = imm_u;
            end
            AUIPC: begin
                e.we   = 1'b1;
                e.data = cur_pc + imm_u;
            end
            OP: begin
                e.we      = 1'b1;
                e.data    = alu_ref(f3, f7[5], a, b);
                e.illegal = !(f7 == 7'b0000000 ||
                              (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101)));
            end
            OP_IMM: begin
                e.we   = 1'b1;
                e.data = alu_ref(f3, f3 == 3'b101 && f7[5], a, imm_i);
                if (f3 == 3'b001) begin
                    e.illegal = f7 != 7'b0000000;
                end else if (f3 == 3'b101) begin
                    e.illegal = f7 != 7'b0000000 && f7 != 7'b0100000;
                end
            end
            JAL: begin
                e.we      = 1'b1;
                e.data    = cur_pc + 4;
                e.next_pc = cur_pc + imm_j;
            end
            JALR: begin
                e.we      = 1'b1;
                e.data    = cur_pc + 4;
                e.next_pc = (a + imm_i) & ~32'd1;
                e.illegal = f3 != 3'b000;
            end
            BRANCH: begin
                case (f3)
                    3'b000:  taken = a == b;
                    3'b001:  taken = a != b;
                    3'b100:  taken = $signed(a) < $signed(b);
                    3'b101:  taken = $signed(a) >= $signed(b);
                    3'b110:  taken = a < b;
                    3'b111:  taken = a >= b;
                    default: e.illegal = 1'b1;
                endcase
                if (taken) begin
                    e.next_pc = cur_pc + imm_b;
                end
            end
            MISC_MEM: begin
                e.fencei  = f3 == 3'b001;
                e.illegal = f3 != 3'b000 && f3 != 3'b001;
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.illegal) begin
            e.we      = 1'b0;
            e.fencei  = 1'b0;
            e.next_pc = cur_pc + 4;
        end
        if (e.rd == '0) begin
            e.we = 1'b0;
        end
        return e;
    endfunction

    task automatic gen_inst(output logic [`RV_XLEN-1:0] word);
        logic [31:0] cls;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] f3;
        logic [31:0] imm;
        logic [31:0] sel;
        logic [6:0]  f7;
        rand_bits(4, cls);
        rand_bits(5, rd);
        rand_bits(5, rs1);
        rand_bits(5, rs2);
        rand_bits(3, f3);
        rand_bits(12, imm);
        rand_bits(2, sel);
        case (cls[3:0])
            4'd1, 4'd2: begin
                if (f3[2:0] == 3'b001) begin
                    imm[11:5] = 7'b0000000;
                end else if (f3[2:0] == 3'b101) begin
                    imm[11:5] = sel[0] ? 7'b0100000 : 7'b0000000;
                end
                word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], OP_IMM};
            end
            4'd3: word = {imm[11:0], rs2[4:0], f3[2:0], rd[4:0], LUI};
            4'd4: word = {imm[11:0], rs2[4:0], f3[2:0], rd[4:0], AUIPC};
            4'd5: word = {imm[11:0], rs2[4:0], f3[2:0], rd[4:0], JAL};
            4'd6: word = {imm[11:0], rs1[4:0], 3'b000, rd[4:0], JALR};
            4'd7, 4'd8: begin
                // 010 and 011 have no branch
                if (f3[2:1] == 2'b01) begin
                    f3[2:0] = f3[2:0] ^ 3'b110;
                end
                word = {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], BRANCH};
            end
            4'd9: begin
                case (sel[1:0])
                    2'd0:    f7 = LOAD;
                    2'd1:    f7 = STORE;
                    2'd2:    f7 = SYSTEM;
                    default: f7 = 7'b0001011;
                endcase
                word = {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], f7};
            end
            4'd10: word = {7'b0000001, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
            4'd11: begin
                word = {1'b1, imm[5:0], rs2[4:0], rs1[4:0], sel[0] ? 3'b101 : 3'b001,
                        rd[4:0], OP_IMM};
            end
            4'd12: word = {imm[11:0], rs1[4:0], 2'b00, sel[0], rd[4:0], MISC_MEM};
            4'd13: word = {imm[11:0], rs1[4:0], 3'b000, 5'd0, OP_IMM};
            default: begin
                f7 = (sel[0] && (f3[2:0] == 3'b000 || f3[2:0] == 3'b101)) ?
                     7'b0100000 : 7'b0000000;
                word = {f7, rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP};
            end
        endcase
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "stopping at first mismatch");
    endtask

    task automatic check_word(input logic [`RV_XLEN-1:0] got, input logic [`RV_XLEN-1:0] exp,
                              input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %h expected %h", what, got, exp));
        end
    endtask

    task automatic check_reg(input logic [`RV_REG_AW-1:0] got,
                             input logic [`RV_REG_AW-1:0] exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got x%0d expected x%0d", what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            report_error($sformatf("%s got %b expected %b", what, got, exp));
        end
    endtask

    always @(posedge clock) begin
        if (reset) begin
            sent_valid <= 1'b0;
        end else begin
            sent_valid <= inst_valid;
        end
        sent_inst <= inst;
    end

    // Outputs are settled by the falling edge
    always @(negedge clock) begin
        if (!reset) begin
            check_flag(retire, sent_valid, "retire");
            if (sent_valid) begin
                exp_rec = predict(model_rf, model_pc, sent_inst);
                check_word(pc, exp_rec.next_pc, $sformatf("pc after %h", sent_inst));
                check_flag(retire_we, exp_rec.we, "retire_we");
                check_flag(retire_illegal, exp_rec.illegal, "retire_illegal");
                check_flag(retire_fencei, exp_rec.fencei, "retire_fencei");
                if (exp_rec.we) begin
                    check_reg(retire_rd, exp_rec.rd, "retire_rd");
                    check_word(retire_data, exp_rec.data,
                               $sformatf("retire_data for %h", sent_inst));
                    model_rf[exp_rec.rd] = exp_rec.data;
                end
                model_pc = exp_rec.next_pc;
            end else begin
                // No strobe, so pc holds and the retire flags stay low
                check_word(pc, model_pc, "pc while idle");
                check_flag(retire_we, 1'b0, "retire_we while idle");
                check_flag(retire_illegal, 1'b0, "retire_illegal while idle");
                check_flag(retire_fencei, 1'b0, "retire_fencei while idle");
            end
        end
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run timed out after %0d cycles", cycle_count);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        logic [`RV_XLEN-1:0] word;
        logic [31:0]         pick;
        int                  idle;
        errors      = 0;
        cycle_count = 0;
        lfsr        = 16'd65;
        reset       = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        model_pc    = `RV_RESET_PC;
        for (int i = 0; i < 32; i++) begin
            model_rf[i] = '0;
        end
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        check_word(pc, `RV_RESET_PC, "pc after reset");
        check_flag(retire, 1'b0, "retire after reset");
        @(posedge clock);
        #1;
        for (int n = 0; n < NUM_INSTS; n++) begin
            gen_inst(word);
            inst       = word;
            inst_valid = 1'b1;
            @(posedge clock);
            #1;
            inst_valid = 1'b0;
            rand_bits(3, pick);
            idle = (pick == 7) ? 2 : (pick == 6) ? 1 : 0;
            repeat (idle) begin
                @(posedge clock);
                #1;
            end
        end
        repeat (2) @(posedge clock);
        #1;
        if (errors == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "run ended with mismatches");
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+common
common/rv_core_pkg.sv
common/dec_if.sv
common/wb_if.sv
idu/idu.sv
exu/exu.sv
hw/wbu.sv
hw/core_top.sv
testbench/core_chk.sv
testbench/tb_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= No errors

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
